// File: hdl/oooCorePkg.sv
`default_nettype none

package oooCorePkg;

    // Sizes
    // ----------------------------------------
    localparam int dataWidth     = 32;
    localparam int numArchRegs   = 16;
    localparam int regIdxWidth   = 4;
    localparam int robDepth      = 16;
    localparam int robTagWidth   = 4;
    localparam int numLanes      = 4;
    localparam int laneIdxWidth  = 2;
    localparam int laneDepth     = 4;
    localparam int laneSlotWidth = 2;
    localparam int immWidth      = 12;

    // Micro-op types
    // ----------------------------------------
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,                                 // Shift amount from the low 5 bits of B
        OP_SRL,
        OP_ADDI                                 // rs1 plus sign-extended immediate
    } aluOp_t;

    typedef struct packed {
        aluOp_t                 op;
        logic [regIdxWidth-1:0] rd;
        logic [regIdxWidth-1:0] rs1;
        logic [regIdxWidth-1:0] rs2;
        logic [immWidth-1:0]    imm;
    } uopReq_t;

    // Either a value or the tag of the reorder-buffer entry that will produce it
    typedef struct packed {
        logic                   ready;
        logic [robTagWidth-1:0] robTag;
        logic [dataWidth-1:0]   value;
    } operand_t;

    typedef struct packed {
        aluOp_t                 op;
        logic [robTagWidth-1:0] robTag;
        operand_t               srcA;
        operand_t               srcB;
    } laneEntry_t;

    // Broadcast and completion records
    // ----------------------------------------
    typedef struct packed {
        logic                   valid;
        logic [robTagWidth-1:0] robTag;
        logic [dataWidth-1:0]   value;
    } result_t;

    typedef struct packed {
        logic [regIdxWidth-1:0] rd;
        logic [robTagWidth-1:0] robTag;
        logic [dataWidth-1:0]   value;
    } commit_t;

    typedef struct packed {
        logic                 done;
        logic [dataWidth-1:0] value;
    } robRead_t;

endpackage

`default_nettype wire

// File: hdl/dispatchStage.sv
`timescale 1ns/100ps
`default_nettype none

module dispatchStage import oooCorePkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire uopReq_t           uop,
    input  wire                    uopValid,
    output logic                   uopReady,
    input  wire [robTagWidth-1:0]  tailTag,
    input  wire                    robFull,
    output logic                   allocate,
    output logic [regIdxWidth-1:0] allocRd,
    output logic [regIdxWidth-1:0] archIdxA,
    output logic [regIdxWidth-1:0] archIdxB,
    input  wire [dataWidth-1:0]    archValueA,
    input  wire [dataWidth-1:0]    archValueB,
    output logic [robTagWidth-1:0] lookupTagA,
    output logic [robTagWidth-1:0] lookupTagB,
    input  wire robRead_t          lookupA,
    input  wire robRead_t          lookupB,
    input  wire result_t           results [numLanes],
    input  wire commit_t           commitInfo,
    input  wire                    commitFire,
    input  wire [numLanes-1:0]     laneFull,
    output logic [numLanes-1:0]    laneWrite,
    output laneEntry_t             laneEntry
);

    logic [numArchRegs-1:0]  aliasPending;
    logic [robTagWidth-1:0]  aliasTag [numArchRegs];
    logic [laneIdxWidth-1:0] lastLane;
    logic [laneIdxWidth-1:0] laneSel;
    logic                    accept;

    // Register file, then a finished ROB entry, then a result on the bus this cycle
    function automatic operand_t resolveSrc(
        input logic                   pending,
        input logic [robTagWidth-1:0] tag,
        input logic [dataWidth-1:0]   archValue,
        input robRead_t               robRead,
        input result_t                bcast [numLanes]
    );
        operand_t src;
        src.ready  = 1'b1;
        src.robTag = tag;
        src.value  = archValue;
        if (pending) begin
            src.ready = robRead.done;
            src.value = robRead.value;
            for (int i = 0; i < numLanes; i++) begin
                if (bcast[i].valid && bcast[i].robTag == tag) begin
                    src.ready = 1'b1;
                    src.value = bcast[i].value;
                end
            end
        end
        return src;
    endfunction

    assign archIdxA   = uop.rs1;
    assign archIdxB   = uop.rs2;
    assign lookupTagA = aliasTag[uop.rs1];
    assign lookupTagB = aliasTag[uop.rs2];

    assign uopReady = !robFull && !(&laneFull);
    assign accept   = uopValid && uopReady;
    assign allocate = accept;
    assign allocRd  = uop.rd;

    always_comb begin
        laneEntry.op     = uop.op;
        laneEntry.robTag = tailTag;                  // ROB tag doubles as the rename tag
        laneEntry.srcA   = resolveSrc(aliasPending[uop.rs1], lookupTagA, archValueA,
                                      lookupA, results);
        laneEntry.srcB   = resolveSrc(aliasPending[uop.rs2], lookupTagB, archValueB,
                                      lookupB, results);
        if (uop.op == OP_ADDI) begin
            laneEntry.srcB.ready  = 1'b1;
            laneEntry.srcB.robTag = '0;
            laneEntry.srcB.value  = {{(dataWidth-immWidth){uop.imm[immWidth-1]}}, uop.imm};
        end
    end

    // Lane steering
    // ----------------------------------------
    // Round robin that starts just past the last lane used
    always_comb begin
        logic [laneIdxWidth-1:0] candidate;
        logic                    found;
        laneSel = lastLane;
        found   = 1'b0;
        for (int k = 1; k <= numLanes; k++) begin
            candidate = lastLane + laneIdxWidth'(k);
            if (!found && !laneFull[candidate]) begin
                laneSel = candidate;
                found   = 1'b1;
            end
        end
    end

    assign laneWrite = {{(numLanes-1){1'b0}}, accept} << laneSel;

    always_ff @(posedge clk) begin
        if (reset) begin
            aliasPending <= '0;
            lastLane     <= laneIdxWidth'(numLanes - 1);   // Lane 0 gets the first micro-op
        end else begin
            if (commitFire && aliasTag[commitInfo.rd] == commitInfo.robTag) begin
                aliasPending[commitInfo.rd] <= 1'b0;
            end
            if (accept) begin
                aliasPending[uop.rd] <= 1'b1;        // A new writer overrides the clear above
                lastLane             <= laneSel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            aliasTag[uop.rd] <= tailTag;
        end
    end

endmodule

`default_nettype wire

// File: hdl/issueLane.sv
`timescale 1ns/100ps
`default_nettype none

module issueLane import oooCorePkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire laneEntry_t entry,
    input  wire             write,
    input  wire result_t    results [numLanes],
    output logic            laneFull,
    output result_t         result
);

    // Reservation slots stay compacted so slot 0 holds the oldest entry
    laneEntry_t               slots     [laneDepth];
    laneEntry_t               woken     [laneDepth];
    laneEntry_t               nextSlots [laneDepth];
    logic [laneSlotWidth:0]   count;
    logic [laneSlotWidth:0]   nextCount;
    logic [laneSlotWidth-1:0] pickIdx;
    logic                     pickHit;

    logic                     issueValid;
    aluOp_t                   issueOp;
    logic [robTagWidth-1:0]   issueTag;
    logic [dataWidth-1:0]     opA;
    logic [dataWidth-1:0]     opB;
    logic [dataWidth-1:0]     aluOut;

    function automatic operand_t wake(input operand_t src, input result_t bcast [numLanes]);
        operand_t woke;
        woke = src;
        for (int i = 0; i < numLanes; i++) begin
            if (!src.ready && bcast[i].valid && bcast[i].robTag == src.robTag) begin
                woke.ready = 1'b1;
                woke.value = bcast[i].value;
            end
        end
        return woke;
    endfunction

    assign laneFull = count == (laneSlotWidth+1)'(laneDepth);

    // Wakeup and select
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < laneDepth; i++) begin
            woken[i]      = slots[i];
            woken[i].srcA = wake(slots[i].srcA, results);
            woken[i].srcB = wake(slots[i].srcB, results);
        end
    end

    always_comb begin
        pickHit = 1'b0;
        pickIdx = '0;
        for (int i = laneDepth - 1; i >= 0; i--) begin
            if (i < count && woken[i].srcA.ready && woken[i].srcB.ready) begin
                pickHit = 1'b1;                      // Lowest index wins, so the oldest
                pickIdx = laneSlotWidth'(i);
            end
        end
    end

    // Close the gap left by the issued entry, then append the new one
    always_comb begin
        nextCount = count - (laneSlotWidth+1)'(pickHit);
        for (int i = 0; i < laneDepth - 1; i++) begin
            nextSlots[i] = (pickHit && i >= pickIdx) ? woken[i + 1] : woken[i];
        end
        nextSlots[laneDepth-1] = woken[laneDepth-1];
        if (write) begin
            nextSlots[nextCount[laneSlotWidth-1:0]] = entry;
            nextCount = nextCount + 1'b1;
        end
    end

    // Integer ALU
    // ----------------------------------------
    always_comb begin
        case (issueOp)
            OP_ADD, OP_ADDI: aluOut = opA + opB;
            OP_SUB:          aluOut = opA - opB;
            OP_AND:          aluOut = opA & opB;
            OP_OR:           aluOut = opA | opB;
            OP_XOR:          aluOut = opA ^ opB;
            OP_SLL:          aluOut = opA << opB[4:0];
            OP_SRL:          aluOut = opA >> opB[4:0];
            default:         aluOut = opA + opB;
        endcase
    end

    always_ff @(posedge clk) begin
        slots         <= nextSlots;
        issueOp       <= woken[pickIdx].op;
        issueTag      <= woken[pickIdx].robTag;
        opA           <= woken[pickIdx].srcA.value;
        opB           <= woken[pickIdx].srcB.value;
        result.robTag <= issueTag;
        result.value  <= aluOut;
        if (reset) begin
            count        <= '0;
            issueValid   <= 1'b0;
            result.valid <= 1'b0;
        end else begin
            count        <= nextCount;
            issueValid   <= pickHit;
            result.valid <= issueValid;             // Broadcast one cycle after issue
        end
    end

endmodule

`default_nettype wire

// File: hdl/reorderBuffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorderBuffer import oooCorePkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    allocate,
    input  wire [regIdxWidth-1:0]  allocRd,
    output logic [robTagWidth-1:0] tailTag,
    output logic                   robFull,
    input  wire [regIdxWidth-1:0]  archIdxA,
    input  wire [regIdxWidth-1:0]  archIdxB,
    output logic [dataWidth-1:0]   archValueA,
    output logic [dataWidth-1:0]   archValueB,
    input  wire [robTagWidth-1:0]  lookupTagA,
    input  wire [robTagWidth-1:0]  lookupTagB,
    output robRead_t               lookupA,
    output robRead_t               lookupB,
    input  wire result_t           results [numLanes],
    output commit_t                commit,
    output logic                   commitValid,
    input  wire                    commitReady,
    output logic                   commitFire
);

    logic [robTagWidth-1:0] head;
    logic [robTagWidth-1:0] tail;
    logic [robTagWidth:0]   count;                   // One wider so a full buffer is visible

    logic [regIdxWidth-1:0] entryRd    [robDepth];
    logic [robDepth-1:0]    entryDone;
    logic [dataWidth-1:0]   entryValue [robDepth];

    logic [dataWidth-1:0]   archRegs   [numArchRegs];

    assign tailTag = tail;
    assign robFull = count == (robTagWidth+1)'(robDepth);

    // Operand read ports
    // ----------------------------------------
    assign archValueA = archRegs[archIdxA];
    assign archValueB = archRegs[archIdxB];

    assign lookupA.done  = entryDone[lookupTagA];
    assign lookupA.value = entryValue[lookupTagA];
    assign lookupB.done  = entryDone[lookupTagB];
    assign lookupB.value = entryValue[lookupTagB];

    // Commit port
    // ----------------------------------------
    // The head stays put until the sink takes it, so the commit holds under back-pressure
    assign commitValid   = (count != '0) && entryDone[head];
    assign commit.rd     = entryRd[head];
    assign commit.robTag = head;
    assign commit.value  = entryValue[head];
    assign commitFire    = commitValid && commitReady;

    // Entry payload
    always_ff @(posedge clk) begin
        if (allocate) begin
            entryRd[tail] <= allocRd;
        end
        for (int i = 0; i < numLanes; i++) begin
            if (results[i].valid) begin
                entryValue[results[i].robTag] <= results[i].value;
            end
        end
    end

    // Pointers, completion flags and the architectural registers
    always_ff @(posedge clk) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            entryDone <= '0;
            for (int r = 0; r < numArchRegs; r++) begin
                archRegs[r] <= '0;
            end
        end else begin
            if (allocate) begin
                entryDone[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            for (int i = 0; i < numLanes; i++) begin
                if (results[i].valid) begin
                    entryDone[results[i].robTag] <= 1'b1;
                end
            end
            if (commitFire) begin
                archRegs[entryRd[head]] <= entryValue[head];
                head                    <= head + 1'b1;
            end
            count <= count + (robTagWidth+1)'(allocate) - (robTagWidth+1)'(commitFire);
        end
    end

endmodule

`default_nettype wire

// File: hdl/oooCore.sv
`timescale 1ns/100ps
`default_nettype none

module oooCore import oooCorePkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire uopReq_t uop,
    input  wire          uopValid,
    output logic         uopReady,
    output commit_t      commit,
    output logic         commitValid,
    input  wire          commitReady
);

    logic                   allocate;
    logic [regIdxWidth-1:0] allocRd;
    logic [robTagWidth-1:0] tailTag;
    logic                   robFull;
    logic [regIdxWidth-1:0] archIdxA;
    logic [regIdxWidth-1:0] archIdxB;
    logic [dataWidth-1:0]   archValueA;
    logic [dataWidth-1:0]   archValueB;
    logic [robTagWidth-1:0] lookupTagA;
    logic [robTagWidth-1:0] lookupTagB;
    robRead_t               lookupA;
    robRead_t               lookupB;
    logic                   commitFire;

    result_t                laneResults [numLanes];  // Seen by every lane, dispatch and the ROB
    logic [numLanes-1:0]    laneFull;
    logic [numLanes-1:0]    laneWrite;
    laneEntry_t             laneEntry;

    dispatchStage dispatch_i (
        .clk,
        .reset,
        .uop,
        .uopValid,
        .uopReady,
        .tailTag,
        .robFull,
        .allocate,
        .allocRd,
        .archIdxA,
        .archIdxB,
        .archValueA,
        .archValueB,
        .lookupTagA,
        .lookupTagB,
        .lookupA,
        .lookupB,
        .results    (laneResults),
        .commitInfo (commit),
        .commitFire,
        .laneFull,
        .laneWrite,
        .laneEntry
    );

    for (genvar i = 0; i < numLanes; i++) begin : lanes
        issueLane lane_i (
            .clk,
            .reset,
            .entry    (laneEntry),
            .write    (laneWrite[i]),
            .results  (laneResults),
            .laneFull (laneFull[i]),
            .result   (laneResults[i])
        );
    end

    reorderBuffer rob_i (
        .clk,
        .reset,
        .allocate,
        .allocRd,
        .tailTag,
        .robFull,
        .archIdxA,
        .archIdxB,
        .archValueA,
        .archValueB,
        .lookupTagA,
        .lookupTagB,
        .lookupA,
        .lookupB,
        .results (laneResults),
        .commit,
        .commitValid,
        .commitReady,
        .commitFire
    );

endmodule

`default_nettype wire

// File: tb/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);

    localparam real halfPeriod  = 4.0;             // 8 ns clock
    localparam int  resetCycles = 10;

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0;                           // Released just after the last reset edge
    end

endmodule

`default_nettype wire

// File: tb/oooCore_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module oooCore_asserts import oooCorePkg::*; (
    input wire          clk,
    input wire          reset,
    input wire          uopReady,
    input wire commit_t commit,
    input wire          commitValid,
    input wire          commitReady
);

    // Commit handshake
    // ----------------------------------------
    // A stalled commit keeps its payload until the sink takes it
    assert property (@(posedge clk) disable iff (reset)
        commitValid && !commitReady |=> commitValid && $stable(commit))
    else $error("commit or commitValid changed while commitReady was low");

    // Reset behavior
    // ----------------------------------------
    assert property (@(posedge clk) reset |=> !commitValid)
    else $error("commitValid was high while reset was applied");

    assert property (@(posedge clk) disable iff (reset) !$isunknown(uopReady))
    else $error("uopReady is unknown after reset");

endmodule

bind oooCore oooCore_asserts asserts_i (.*);

`default_nettype wire

// File: tb/oooCore_tb.sv
`timescale 1ns/100ps
`default_nettype none

module oooCore_tb import oooCorePkg::*; ();

    localparam int numCases   = 30;
    localparam int numFields  = 7;
    localparam int clkPeriod  = 8;
    localparam int driveDelay = 1;
    localparam int timeoutNs  = numCases * 50 * clkPeriod;
    localparam int stallCycles = robDepth + 8;

    logic        clk;
    logic        reset;
    uopReq_t     uop;
    logic        uopValid;
    logic        uopReady;
    commit_t     commit;
    logic        commitValid;
    logic        commitReady;

    logic [31:0] caseMem [numCases*numFields];     // Seven hex columns per micro-op
    integer      seed        = 32'h5589_70b9;
    int          acceptCount = 0;
    int          commitCount = 0;
    int          valueErrors = 0;
    int          flowErrors  = 0;

    clockGen clock_i (.clk, .reset);

    oooCore dut_i (
        .clk,
        .reset,
        .uop,
        .uopValid,
        .uopReady,
        .commit,
        .commitValid,
        .commitReady
    );

    // Holds the micro-op until the edge where uopReady was seen high
    task automatic sendUop(input int idx);
        int   base;
        logic taken;
        base     = idx * numFields;
        uop.op   = aluOp_t'(caseMem[base][2:0]);
        uop.rd   = caseMem[base+1][regIdxWidth-1:0];
        uop.rs1  = caseMem[base+2][regIdxWidth-1:0];
        uop.rs2  = caseMem[base+3][regIdxWidth-1:0];
        uop.imm  = caseMem[base+4][immWidth-1:0];
        uopValid = 1'b1;
        do begin
            @(negedge clk);
            taken = uopReady;
            @(posedge clk);
            #driveDelay;
        end while (!taken);
        uopValid = 1'b0;
    endtask

    task automatic checkCommit;
        int                     base;
        logic [regIdxWidth-1:0] expRd;
        logic [31:0]            expValue;
        assert (commitCount < numCases) else begin
            flowErrors++;
            $display("An extra commit arrived after all %0d cases had committed", numCases);
        end
        if (commitCount < numCases) begin
            base     = commitCount * numFields;
            expRd    = caseMem[base+5][regIdxWidth-1:0];
            expValue = caseMem[base+6];
            assert (commit.robTag == robTagWidth'(commitCount)) else begin
                valueErrors++;
                $display("error commit.robTag case %0d: got 0x%h, expected 0x%h",
                         commitCount, commit.robTag, robTagWidth'(commitCount));
            end
            assert (commit.rd == expRd) else begin
                valueErrors++;
                $display("error commit.rd case %0d: got 0x%h, expected 0x%h",
                         commitCount, commit.rd, expRd);
            end
            assert (commit.value == expValue) else begin
                valueErrors++;
                $display("error commit.value case %0d: got 0x%h, expected 0x%h",
                         commitCount, commit.value, expValue);
            end
        end
    endtask

    task automatic reportCounts;
        $display("Errors: %0d value, %0d flow, %0d total with %0d of %0d cases committed",
                 valueErrors, flowErrors, valueErrors + flowErrors, commitCount, numCases);
    endtask

    // Monitor
    // ----------------------------------------
    // Both handshakes are stable at the falling edge before the edge that transfers them
    always @(negedge clk) begin
        if (reset === 1'b0) begin
            if (uopValid && uopReady) begin
                acceptCount++;
            end
            if (commitValid && commitReady) begin
                checkCommit();
                commitCount++;
            end
            assert (acceptCount - commitCount <= robDepth) else begin
                flowErrors++;
                $display("Too many micro-ops outstanding with %0d accepted and %0d committed",
                         acceptCount, commitCount);
            end
        end
    end

    initial begin : backPressure
        @(negedge reset);
        repeat (stallCycles) @(posedge clk);       // Sustained stall first so the ROB fills up
        forever begin
            @(posedge clk);
            #driveDelay;
            commitReady = ($unsigned($random(seed)) % 100) >= 30;   // Low about 30% of cycles
        end
    end

    initial begin : stimulus
        uop         = '0;
        uopValid    = 1'b0;
        commitReady = 1'b0;
        $readmemh("tb/oooCore_cases.txt", caseMem);
        @(negedge reset);
        @(negedge clk);
        assert (commitValid == 1'b0) else begin
            valueErrors++;
            $display("error commitValid after reset: got 0x%h, expected 0x0", commitValid);
        end
        assert (uopReady == 1'b1) else begin
            valueErrors++;
            $display("error uopReady after reset: got 0x%h, expected 0x1", uopReady);
        end
        @(posedge clk);
        #driveDelay;
        for (int i = 0; i < numCases; i++) begin
            sendUop(i);
        end
        wait (commitCount == numCases);
        repeat (20) @(posedge clk);                // A stray extra commit would show up here
        assert (acceptCount == numCases) else begin
            flowErrors++;
            $display("The core accepted %0d micro-ops instead of %0d", acceptCount, numCases);
        end
        reportCounts();
        if (valueErrors + flowErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeoutNs);
        $display("Timeout because the stream did not drain within %0d ns", timeoutNs);
        reportCounts();
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hdl/oooCorePkg.sv
hdl/dispatchStage.sv
hdl/issueLane.sv
hdl/reorderBuffer.sv
hdl/oooCore.sv
tb/clockGen.sv
tb/oooCore_asserts.sv
tb/oooCore_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = oooCore_tb
FILELIST = src.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))
PASSMSG  = *** TEST PASSED ***

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)

// File: tb/oooCore_cases.txt
// Each line holds opcode, rd, rs1, rs2, imm, expected rd and expected value in hex
// Opcode 0 is add, then sub, and, or, xor, sll, srl, and 7 is addi
7 1 0 0 005 1 00000005
7 2 0 0 ffd 2 fffffffd
0 3 1 2 000 3 00000002
1 4 1 2 000 4 00000008
7 5 0 0 7ff 5 000007ff
7 6 0 0 800 6 fffff800
2 7 5 6 000 7 00000000
3 8 5 6 000 8 ffffffff
4 9 8 1 000 9 fffffffa
7 a 0 0 014 a 00000014
5 b 1 a 000 b 00500000
6 c 8 a 000 c 00000fff
7 d 0 0 03f d 0000003f
5 e 1 d 000 e 80000000
6 f e d 000 f 00000001
7 3 3 0 001 3 00000003
7 3 3 0 010 3 00000013
0 4 3 3 000 4 00000026
7 3 0 0 100 3 00000100
1 0 3 4 000 0 000000da
7 0 0 0 fff 0 000000d9
4 1 0 9 000 1 ffffff23
2 2 1 c 000 2 00000f23
3 5 2 b 000 5 00500f23
6 6 5 f 000 6 00280791
1 7 0 6 000 7 ffd7f948
7 8 0 0 123 8 000001fc
0 9 f f 000 9 00000002
5 a f a 000 a 00100000
0 b 7 6 000 b 000000d9
